//--- dma_config.svh
// ----------------------------------------------------------------------
// DMA copy datapath dimensions: word lanes, addressing and buffering
// ----------------------------------------------------------------------
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Byte lanes per data word
`define DMA_STRB_WIDTH 4

// Word address width of both memory ports
`define DMA_ADDR_WIDTH 16

// Beat counter width, bounds the burst length
`define DMA_BEAT_WIDTH 8

// Entries per byte lane in the dataflow buffer
`define DMA_BUFFER_DEPTH 3

`endif

//--- dma_pkg.sv
// ----------------------------------------------------------------------
// DMA copy datapath types: lanes, words, burst requests, memory ports
// ----------------------------------------------------------------------
`include "dma_config.svh"

package dma_pkg;

    typedef logic [7:0]                          byte_t;
    typedef logic [`DMA_STRB_WIDTH-1:0]          strb_t;
    typedef logic [$clog2(`DMA_STRB_WIDTH)-1:0]  lane_idx_t;
    typedef byte_t [`DMA_STRB_WIDTH-1:0]         data_t;
    typedef logic [`DMA_ADDR_WIDTH-1:0]          waddr_t;
    typedef logic [`DMA_BEAT_WIDTH-1:0]          beats_t;

    // One burst, shared by the read and the write side
    typedef struct packed {
        waddr_t    addr;
        lane_idx_t offset;
        lane_idx_t tailer;     // 0 means the last beat is full
        lane_idx_t shift;
        beats_t    num_beats;
    } dp_req_t;

    // Memory port, request and response
    typedef struct packed {
        logic   req;
        logic   we;
        waddr_t addr;
        data_t  wdata;
        strb_t  be;
    } mem_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {RD_IDLE, RD_ISSUE, RD_WAIT, RD_PUSH, RD_DONE} rd_state_e;
    typedef enum logic [2:0] {WR_IDLE, WR_COLLECT, WR_ISSUE, WR_ACK, WR_DONE} wr_state_e;

endpackage

//--- dma_mem_read.sv
// ----------------------------------------------------------------------
// Read stage: fetches source words, masks and rotates them into lanes
// ----------------------------------------------------------------------
`include "dma_config.svh"

module dma_mem_read (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dma_pkg::dp_req_t  req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    output dma_pkg::mem_req_t mem_req_o,
    input  dma_pkg::mem_rsp_t mem_rsp_i,
    output dma_pkg::data_t    buf_data_o,
    output dma_pkg::strb_t    buf_valid_o,
    input  dma_pkg::strb_t    buf_ready_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic              busy_o
);
    import dma_pkg::*;

    localparam int unsigned DataWidth = `DMA_STRB_WIDTH * 8;

    rd_state_e state_q, state_d;
    dp_req_t   req_q;
    waddr_t    addr_q;
    beats_t    beat_q;
    data_t     data_q;
    strb_t     pend_q;

    logic  last_beat, beat_accepted;
    strb_t first_mask, last_mask, beat_mask, pend_next;
    logic [2*DataWidth-1:0]       data_dbl;
    logic [2*`DMA_STRB_WIDTH-1:0] mask_dbl;

    // ------------------------------------------------------------------
    // Beat mask and barrel shift
    // ------------------------------------------------------------------
    assign first_mask = '1 << req_q.offset;
    assign last_mask  = (req_q.tailer == '0) ? '1 : ~('1 << req_q.tailer);
    assign last_beat  = beat_q == (req_q.num_beats - beats_t'(1));
    assign beat_mask  = ((beat_q == '0) ? first_mask : '1) & (last_beat ? last_mask : '1);

    // Rotate right so the first valid source byte lands on lane 0
    assign data_dbl = {mem_rsp_i.rdata, mem_rsp_i.rdata} >> (req_q.shift * 8);
    assign mask_dbl = {beat_mask, beat_mask} >> req_q.shift;

    assign pend_next     = pend_q & ~buf_ready_i;
    assign beat_accepted = (state_q == RD_PUSH) && (pend_next == '0);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RD_IDLE:  if (req_valid_i)          state_d = RD_ISSUE;
            RD_ISSUE: if (mem_rsp_i.gnt)        state_d = RD_WAIT;
            RD_WAIT:  if (mem_rsp_i.rvalid)     state_d = RD_PUSH;
            RD_PUSH:  if (pend_next == '0)      state_d = last_beat ? RD_DONE : RD_ISSUE;
            RD_DONE:  if (rsp_ready_i)          state_d = RD_IDLE;
            default:                            state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= RD_IDLE;
            pend_q  <= '0;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RD_WAIT && mem_rsp_i.rvalid) begin
                pend_q <= mask_dbl[`DMA_STRB_WIDTH-1:0];
            end else if (state_q == RD_PUSH) begin
                pend_q <= pend_next;
            end
            if (state_q == RD_IDLE) begin
                beat_q <= '0;
            end else if (beat_accepted) begin
                beat_q <= beat_q + beats_t'(1);
            end
        end
    end

    // Burst and word payload
    always_ff @(posedge clk_i) begin
        if (state_q == RD_IDLE && req_valid_i) begin
            req_q  <= req_i;
            addr_q <= req_i.addr;
        end else if (beat_accepted) begin
            addr_q <= addr_q + waddr_t'(1);
        end
        if (state_q == RD_WAIT && mem_rsp_i.rvalid) begin
            data_q <= data_dbl[DataWidth-1:0];
        end
    end

    always_comb begin
        mem_req_o      = '0;
        mem_req_o.req  = state_q == RD_ISSUE;
        mem_req_o.addr = addr_q;
        mem_req_o.be   = '1;
    end

    assign buf_data_o  = data_q;
    assign buf_valid_o = pend_q;
    assign req_ready_o = state_q == RD_IDLE;
    assign rsp_valid_o = state_q == RD_DONE;
    assign busy_o      = state_q != RD_IDLE;

    // Request fields hold until the memory grants
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o.req && !mem_rsp_i.gnt |=> mem_req_o.req && $stable(mem_req_o));

    // Memory returns data only while a read is outstanding
    a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_i.rvalid |-> state_q == RD_WAIT);

endmodule

//--- dma_byte_buffer.sv
// ----------------------------------------------------------------------
// Dataflow buffer with one small byte FIFO per lane between read and write
// ----------------------------------------------------------------------
`include "dma_config.svh"

module dma_byte_buffer #(
    parameter int unsigned Depth = `DMA_BUFFER_DEPTH
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  dma_pkg::data_t in_data_i,
    input  dma_pkg::strb_t in_valid_i,
    output dma_pkg::strb_t in_ready_o,
    output dma_pkg::data_t out_data_o,
    output dma_pkg::strb_t out_valid_o,
    input  dma_pkg::strb_t out_ready_i,
    output logic           busy_o
);
    import dma_pkg::*;

    localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    for (genvar i = 0; i < `DMA_STRB_WIDTH; i++) begin : gen_lane
        byte_t                mem_q [Depth];
        logic [PtrWidth-1:0]  wr_ptr_q, rd_ptr_q;
        logic [CntWidth-1:0]  count_q;
        logic                 push, pop;

        assign in_ready_o[i]  = count_q != CntWidth'(Depth);
        assign out_valid_o[i] = count_q != '0;
        assign out_data_o[i]  = mem_q[rd_ptr_q];

        assign push = in_valid_i[i] && in_ready_o[i];
        assign pop  = out_valid_o[i] && out_ready_i[i];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                if (push && !pop) begin
                    count_q <= count_q + 1'b1;
                end else if (pop && !push) begin
                    count_q <= count_q - 1'b1;
                end
            end
        end

        // Byte storage
        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wr_ptr_q] <= in_data_i[i];
            end
        end

        // A byte never lands on the unread head of a lane that holds data
        a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            push && (count_q != '0) |-> wr_ptr_q != rd_ptr_q);
    end

    assign busy_o = |out_valid_o;

endmodule

//--- dma_mem_write.sv
// ----------------------------------------------------------------------
// Write stage: gathers lane bytes, aligns them and writes with enables
// ----------------------------------------------------------------------
`include "dma_config.svh"

module dma_mem_write (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dma_pkg::dp_req_t  req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  dma_pkg::data_t    buf_data_i,
    input  dma_pkg::strb_t    buf_valid_i,
    output dma_pkg::strb_t    buf_ready_o,
    output dma_pkg::mem_req_t mem_req_o,
    input  dma_pkg::mem_rsp_t mem_rsp_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic              busy_o
);
    import dma_pkg::*;

    localparam int unsigned DataWidth = `DMA_STRB_WIDTH * 8;

    wr_state_e state_q, state_d;
    dp_req_t   req_q;
    waddr_t    addr_q;
    beats_t    beat_q;

    logic      last_beat, beat_ready, beat_acked;
    lane_idx_t back_shift;
    strb_t     first_mask, last_mask, beat_mask, valid_rot;
    logic [2*DataWidth-1:0]       data_dbl;
    logic [2*`DMA_STRB_WIDTH-1:0] valid_dbl, ready_dbl;

    // ------------------------------------------------------------------
    // Byte enables and barrel shift
    // ------------------------------------------------------------------
    assign first_mask = '1 << req_q.offset;
    assign last_mask  = (req_q.tailer == '0) ? '1 : ~('1 << req_q.tailer);
    assign last_beat  = beat_q == (req_q.num_beats - beats_t'(1));
    assign beat_mask  = ((beat_q == '0) ? first_mask : '1) & (last_beat ? last_mask : '1);

    // Left rotation by shift, done as a right rotation by its complement
    assign back_shift = -req_q.shift;
    assign data_dbl   = {buf_data_i, buf_data_i} >> (back_shift * 8);
    assign valid_dbl  = {buf_valid_i, buf_valid_i} >> back_shift;
    assign valid_rot  = valid_dbl[`DMA_STRB_WIDTH-1:0];

    // Enables mapped back onto the buffer lanes they came from
    assign ready_dbl  = {beat_mask, beat_mask} >> req_q.shift;

    assign beat_ready = (valid_rot & beat_mask) == beat_mask;
    assign beat_acked = (state_q == WR_ACK) && mem_rsp_i.rvalid;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WR_IDLE:    if (req_valid_i)       state_d = WR_COLLECT;
            WR_COLLECT: if (beat_ready)        state_d = WR_ISSUE;
            WR_ISSUE:   if (mem_rsp_i.gnt)     state_d = WR_ACK;
            WR_ACK:     if (mem_rsp_i.rvalid)  state_d = last_beat ? WR_DONE : WR_COLLECT;
            WR_DONE:    if (rsp_ready_i)       state_d = WR_IDLE;
            default:                           state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == WR_IDLE) begin
                beat_q <= '0;
            end else if (beat_acked) begin
                beat_q <= beat_q + beats_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == WR_IDLE && req_valid_i) begin
            req_q  <= req_i;
            addr_q <= req_i.addr;
        end else if (beat_acked) begin
            addr_q <= addr_q + waddr_t'(1);
        end
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.req   = state_q == WR_ISSUE;
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = data_dbl[DataWidth-1:0];
        mem_req_o.be    = beat_mask;
    end

    // Pop the used lanes only once the memory has taken the word
    assign buf_ready_o = (state_q == WR_ISSUE && mem_rsp_i.gnt) ?
                         ready_dbl[`DMA_STRB_WIDTH-1:0] : '0;

    assign req_ready_o = state_q == WR_IDLE;
    assign rsp_valid_o = state_q == WR_DONE;
    assign busy_o      = state_q != WR_IDLE;

    // Every issued write carries at least one byte
    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o.req |-> mem_req_o.be != '0);

endmodule

//--- dma_transport.sv
// ----------------------------------------------------------------------
// DMA transport layer: read port, byte buffer and write port in a line
// ----------------------------------------------------------------------
module dma_transport (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dma_pkg::dp_req_t  r_req_i,
    input  logic              r_req_valid_i,
    output logic              r_req_ready_o,
    output logic              r_rsp_valid_o,
    input  logic              r_rsp_ready_i,
    input  dma_pkg::dp_req_t  w_req_i,
    input  logic              w_req_valid_i,
    output logic              w_req_ready_o,
    output logic              w_rsp_valid_o,
    input  logic              w_rsp_ready_i,
    output dma_pkg::mem_req_t src_mem_req_o,
    input  dma_pkg::mem_rsp_t src_mem_rsp_i,
    output dma_pkg::mem_req_t dst_mem_req_o,
    input  dma_pkg::mem_rsp_t dst_mem_rsp_i,
    output logic              r_busy_o,
    output logic              w_busy_o,
    output logic              buffer_busy_o
);
    import dma_pkg::*;

    // Lanes between the read port and the buffer
    data_t buf_in_data;
    strb_t buf_in_valid, buf_in_ready;
    // Lanes between the buffer and the write port
    data_t buf_out_data;
    strb_t buf_out_valid, buf_out_ready;

    dma_mem_read i_mem_read (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (r_req_i),
        .req_valid_i (r_req_valid_i),
        .req_ready_o (r_req_ready_o),
        .mem_req_o   (src_mem_req_o),
        .mem_rsp_i   (src_mem_rsp_i),
        .buf_data_o  (buf_in_data),
        .buf_valid_o (buf_in_valid),
        .buf_ready_i (buf_in_ready),
        .rsp_valid_o (r_rsp_valid_o),
        .rsp_ready_i (r_rsp_ready_i),
        .busy_o      (r_busy_o)
    );

    dma_byte_buffer i_byte_buffer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_data_i   (buf_in_data),
        .in_valid_i  (buf_in_valid),
        .in_ready_o  (buf_in_ready),
        .out_data_o  (buf_out_data),
        .out_valid_o (buf_out_valid),
        .out_ready_i (buf_out_ready),
        .busy_o      (buffer_busy_o)
    );

    dma_mem_write i_mem_write (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (w_req_i),
        .req_valid_i (w_req_valid_i),
        .req_ready_o (w_req_ready_o),
        .buf_data_i  (buf_out_data),
        .buf_valid_i (buf_out_valid),
        .buf_ready_o (buf_out_ready),
        .mem_req_o   (dst_mem_req_o),
        .mem_rsp_i   (dst_mem_rsp_i),
        .rsp_valid_o (w_rsp_valid_o),
        .rsp_ready_i (w_rsp_ready_i),
        .busy_o      (w_busy_o)
    );

endmodule

//--- tb_dma_mem_model.sv
// ----------------------------------------------------------------------
// Testbench memory: word array with random grant, one-cycle response
// ----------------------------------------------------------------------
`include "dma_config.svh"

module tb_dma_mem_model #(
    parameter int unsigned Words = 64
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  int unsigned       gnt_pct_i,
    input  dma_pkg::mem_req_t req_i,
    output dma_pkg::mem_rsp_t rsp_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    data_t mem [Words];
    logic  gnt_en, gnt_next, rvalid_q, hit;
    data_t rdata_q, word;

    initial begin
        gnt_en   = 1'b0;
        rvalid_q = 1'b0;
        rdata_q  = '0;
    end

    always @(posedge clk_i) begin
        // Sample the access at the edge, answer shortly after it
        hit      = rst_n_i && req_i.req && gnt_en;
        word     = mem[req_i.addr % Words];
        gnt_next = $urandom_range(99) < gnt_pct_i;
        if (hit && req_i.we) begin
            for (int l = 0; l < `DMA_STRB_WIDTH; l++) begin
                if (req_i.be[l]) begin
                    word[l] = req_i.wdata[l];
                end
            end
            mem[req_i.addr % Words] = word;
        end
        #1;
        rvalid_q = hit;
        rdata_q  = word;
        gnt_en   = gnt_next;
    end

    always_comb begin
        rsp_o.gnt    = rst_n_i && req_i.req && gnt_en;
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
    end

endmodule

//--- tb_dma_transport.sv
// ----------------------------------------------------------------------
// Testbench for the DMA transport with a table of copies checked by byte
// ----------------------------------------------------------------------
`include "dma_config.svh"

module tb_dma_transport;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    localparam int unsigned Lanes    = `DMA_STRB_WIDTH;
    localparam int unsigned Words    = 64;
    localparam int unsigned Timeout  = 2000;
    localparam int unsigned NumXfers = 6;

    // Source byte address, destination byte address, length, grant percent, response stall
    typedef struct packed {
        logic [15:0] src;
        logic [15:0] dst;
        logic [15:0] len;
        logic [7:0]  gnt_pct;
        logic [7:0]  stall;
    } xfer_t;

    localparam xfer_t Xfers [NumXfers] = '{
        '{16'd0,  16'd64,  16'd16, 8'd100, 8'd0},
        '{16'd5,  16'd130, 16'd11, 8'd100, 8'd1},
        '{16'd7,  16'd161, 16'd1,  8'd60,  8'd0},
        '{16'd18, 16'd195, 16'd3,  8'd70,  8'd2},
        '{16'd33, 16'd226, 16'd21, 8'd50,  8'd5},
        '{16'd2,  16'd100, 16'd2,  8'd40,  8'd3}
    };

    logic        clk_i;
    logic        rst_n_i;
    dp_req_t     r_req_i;
    dp_req_t     w_req_i;
    logic        r_req_valid_i, r_req_ready_o, r_rsp_valid_o, r_rsp_ready_i;
    logic        w_req_valid_i, w_req_ready_o, w_rsp_valid_o, w_rsp_ready_i;
    mem_req_t    src_mem_req_o, dst_mem_req_o;
    mem_rsp_t    src_mem_rsp_i, dst_mem_rsp_i;
    logic        r_busy_o, w_busy_o, buffer_busy_o;
    int unsigned gnt_pct;
    byte_t       dst_shadow [Words*Lanes];

    dma_transport i_dut (.*);

    tb_dma_mem_model #(.Words(Words)) i_src_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .gnt_pct_i (gnt_pct),
        .req_i     (src_mem_req_o),
        .rsp_o     (src_mem_rsp_i)
    );

    tb_dma_mem_model #(.Words(Words)) i_dst_mem (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .gnt_pct_i (gnt_pct),
        .req_i     (dst_mem_req_o),
        .rsp_o     (dst_mem_rsp_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Reference rules and failure reporting
    // ------------------------------------------------------------------
    function automatic byte_t src_byte(input int unsigned addr);
        return byte_t'((addr & 32'hff) * 3);
    endfunction

    function automatic byte_t dst_fill(input int unsigned addr);
        return byte_t'(addr * 5 + 32'h5a);
    endfunction

    function automatic dp_req_t make_req(input int unsigned addr, input int unsigned len);
        dp_req_t     req;
        int unsigned off;
        off           = addr % Lanes;
        req.addr      = waddr_t'(addr / Lanes);
        req.offset    = lane_idx_t'(off);
        req.tailer    = lane_idx_t'((addr + len) % Lanes);
        req.shift     = lane_idx_t'(off);
        req.num_beats = beats_t'((off + len + Lanes - 1) / Lanes);
        return req;
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s at %0t", what, $time);
        abort_run();
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_idle();
        check_flag("src_mem_req_o.req", 1'b0, src_mem_req_o.req);
        check_flag("dst_mem_req_o.req", 1'b0, dst_mem_req_o.req);
        check_flag("r_rsp_valid_o", 1'b0, r_rsp_valid_o);
        check_flag("w_rsp_valid_o", 1'b0, w_rsp_valid_o);
        check_flag("r_busy_o", 1'b0, r_busy_o);
        check_flag("w_busy_o", 1'b0, w_busy_o);
        check_flag("buffer_busy_o", 1'b0, buffer_busy_o);
        check_flag("r_req_ready_o", 1'b1, r_req_ready_o);
        check_flag("w_req_ready_o", 1'b1, w_req_ready_o);
    endtask

    // ------------------------------------------------------------------
    // Handshakes sampled one step after the clock edge
    // ------------------------------------------------------------------
    task automatic send_requests(input dp_req_t rd, input dp_req_t wr);
        int unsigned cycles;
        logic        r_hs, w_hs;
        cycles        = 0;
        r_req_i       = rd;
        w_req_i       = wr;
        r_req_valid_i = 1'b1;
        w_req_valid_i = 1'b1;
        while (r_req_valid_i || w_req_valid_i) begin
            r_hs = r_req_valid_i && r_req_ready_o;
            w_hs = w_req_valid_i && w_req_ready_o;
            @(posedge clk_i);
            #1;
            if (r_hs) begin
                r_req_valid_i = 1'b0;
            end
            if (w_hs) begin
                w_req_valid_i = 1'b0;
            end
            cycles++;
            if (cycles > Timeout) begin
                report_timeout("a request handshake");
            end
        end
    endtask

    task automatic take_response(input logic is_write, input int unsigned stall);
        int unsigned cycles;
        string       name;
        string       busy_name;
        cycles    = 0;
        name      = is_write ? "w_rsp_valid_o" : "r_rsp_valid_o";
        busy_name = is_write ? "w_busy_o" : "r_busy_o";
        while (!(is_write ? w_rsp_valid_o : r_rsp_valid_o)) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles > Timeout) begin
                report_timeout(name);
            end
        end
        // A stage holding its response is still busy
        check_flag(busy_name, 1'b1, is_write ? w_busy_o : r_busy_o);
        // Ready stays low, so the response has to hold
        repeat (stall) begin
            @(posedge clk_i);
            #1;
            check_flag(name, 1'b1, is_write ? w_rsp_valid_o : r_rsp_valid_o);
        end
        if (is_write) begin
            w_rsp_ready_i = 1'b1;
        end else begin
            r_rsp_ready_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        w_rsp_ready_i = 1'b0;
        r_rsp_ready_i = 1'b0;
        check_flag(name, 1'b0, is_write ? w_rsp_valid_o : r_rsp_valid_o);
    endtask

    task automatic verify_copy(input xfer_t row);
        data_t       exp_word;
        int unsigned addr;
        for (int unsigned n = 0; n < row.len; n++) begin
            addr             = row.dst + n;
            dst_shadow[addr] = src_byte(row.src + n);
            check_byte($sformatf("dst_mem byte %0d", addr), dst_shadow[addr],
                       i_dst_mem.mem[addr / Lanes][addr % Lanes]);
        end
        // Bytes outside the copied range keep their old values
        for (int unsigned w = 0; w < Words; w++) begin
            for (int unsigned l = 0; l < Lanes; l++) begin
                exp_word[l] = dst_shadow[w * Lanes + l];
            end
            check_word($sformatf("dst_mem word %0d", w), exp_word, i_dst_mem.mem[w]);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        xfer_t row;
        void'($urandom(32'h7373));
        rst_n_i       = 1'b0;
        r_req_i       = '0;
        w_req_i       = '0;
        r_req_valid_i = 1'b0;
        w_req_valid_i = 1'b0;
        r_rsp_ready_i = 1'b0;
        w_rsp_ready_i = 1'b0;
        gnt_pct       = 100;
        for (int unsigned a = 0; a < Words * Lanes; a++) begin
            i_src_mem.mem[a / Lanes][a % Lanes] = src_byte(a);
            i_dst_mem.mem[a / Lanes][a % Lanes] = dst_fill(a);
            dst_shadow[a]                        = dst_fill(a);
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_idle();

        for (int unsigned i = 0; i < NumXfers; i++) begin
            row     = Xfers[i];
            gnt_pct = row.gnt_pct;
            send_requests(make_req(row.src, row.len), make_req(row.dst, row.len));
            take_response(1'b0, row.stall);
            take_response(1'b1, row.stall);
            check_idle();
            verify_copy(row);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
dma_pkg.sv
dma_mem_read.sv
dma_byte_buffer.sv
dma_mem_write.sv
dma_transport.sv
tb_dma_mem_model.sv
tb_dma_transport.sv

//--- Bender.yml
package:
  name: dma_transport

sources:
  - include_dirs:
      - .
    files:
      - dma_pkg.sv
      - dma_mem_read.sv
      - dma_byte_buffer.sv
      - dma_mem_write.sv
      - dma_transport.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dma_mem_model.sv
      - tb_dma_transport.sv
